/* build.f */
source/isaPkg.sv
source/pipeBusPkg.sv
source/wbPipeReg.sv
source/loadExtend.sv
source/wbStage.sv
source/archRegFile.sv
source/wbTop.sv
dv/wbTop_assertions.sv
dv/wbTb.sv

/* Makefile */
# Verilator build and run for the writeback subsystem

VERILATOR ?= verilator
TOP       ?= wbTb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ** PASS **

SIM_BIN = ./$(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Simulation output is searched for the pass line, exit status follows grep
run: compile
	@output="$$($(SIM_BIN))"; \
	echo "$$output"; \
	echo "$$output" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

/* dv/wbTb.sv */
// Writeback subsystem testbench
module wbTb;
    import isaPkg::*;
    import pipeBusPkg::*;

    localparam int ReadPorts   = 2;
    localparam int ResetCycles = 3;

    // Steps per test, one item each
    localparam int SelSteps      = 160;
    localparam int LoadSteps     = 6 * 4 * 4;
    localparam int StallRounds   = 4;
    localparam int StallHold     = 6;
    localparam int FlushIdle     = 3;
    localparam int StallSteps    = StallRounds * (StallHold + FlushIdle + 2);
    localparam int DisRounds     = 8;
    localparam int DisSteps      = DisRounds * 5;
    localparam int DisRandSteps  = 64;
    localparam int HiLoSteps     = 16;
    localparam int SweepSteps    = RegCount;
    localparam int DrainSteps    = 4;
    localparam int TotalSteps    = SelSteps + LoadSteps + StallSteps + DisSteps
                                 + DisRandSteps + HiLoSteps + 5 * SweepSteps + DrainSteps;
    localparam int TimeoutCycles = 3 * TotalSteps + ResetCycles;

    logic        clk;
    logic        reset;
    logic        wbFlush;
    logic        wbWr;
    logic        wbDisWr;
    mem2WbS      mem2Bus;
    logic [4:0]  readAddr [ReadPorts];
    logic [31:0] readData [ReadPorts];
    logic [31:0] hiData;
    logic [31:0] loData;
    logic [31:0] wbResult;
    logic [4:0]  wbDst;
    regsWrS      finalWr;

    // Reference state, mirrors stage register and register file
    mem2WbS      expStage;
    logic [31:0] shadowGpr [RegCount];
    logic [31:0] shadowHi;
    logic [31:0] shadowLo;
    logic        modelReady;
    logic [31:0] wrValue;
    logic [31:0] expValue;
    regsWrS      expWr;

    logic [31:0] rngState;
    int          errorCount;
    int          checkCount;
    int          cycleCount;
    string       testName;

    wbTop #(
        .ReadPorts (ReadPorts)
    ) u_dut (
        .clk      (clk),
        .reset    (reset),
        .wbFlush  (wbFlush),
        .wbWr     (wbWr),
        .wbDisWr  (wbDisWr),
        .mem2Bus  (mem2Bus),
        .readAddr (readAddr),
        .readData (readData),
        .hiData   (hiData),
        .loData   (loData),
        .wbResult (wbResult),
        .wbDst    (wbDst),
        .finalWr  (finalWr)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic logic [4:0] randAddr();
        logic [31:0] r;
        r = nextRand();
        return r[4:0];
    endfunction

    // Fully random bus item, load kind kept to legal values
    function automatic mem2WbS randItem();
        mem2WbS      b;
        logic [31:0] r;
        r          = nextRand();
        b.aluOut   = nextRand();
        b.pc       = nextRand();
        b.operandB = nextRand();
        b.dmOut    = nextRand();
        b.wbSel    = wbSelE'(r[1:0]);
        b.dst      = r[6:2];
        b.loadKind = loadKindE'(3'(r[15:8] % 8'd6));
        b.regsWr   = regsWrS'(r[18:16]);
        return b;
    endfunction

    // Shift the addressed lane down, then extend
    function automatic logic [31:0] extendLoad(input logic [31:0] dm, input logic [1:0] off,
                                               input loadKindE kind);
        logic [31:0] byteShift;
        logic [31:0] halfShift;
        byteShift = dm >> (8 * off);
        halfShift = dm >> (16 * off[1]);
        case (kind)
            LoadLb:  return {{24{byteShift[7]}}, byteShift[7:0]};
            LoadLbu: return {24'd0, byteShift[7:0]};
            LoadLh:  return {{16{halfShift[15]}}, halfShift[15:0]};
            LoadLhu: return {16'd0, halfShift[15:0]};
            default: return dm;
        endcase
    endfunction

    // Expected writeback value for one stage item
    function automatic logic [31:0] expectedResult(input mem2WbS b);
        case (b.wbSel)
            WbPcPlus8:  return b.pc + 32'd8;
            WbAluOut:   return b.aluOut;
            WbOperandB: return b.operandB;
            default:    return extendLoad(b.dmOut, b.aluOut[1:0], b.loadKind);
        endcase
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("mismatch %s %s: expected %08h, actual %08h",
                 testName, what, expected, actual);
    endtask

    // One clock of stimulus
    task automatic issue(input mem2WbS item, input logic wr, input logic flush,
                         input logic disWr, input logic [4:0] ra0, input logic [4:0] ra1);
        @(posedge clk);
        mem2Bus     <= item;
        wbWr        <= wr;
        wbFlush     <= flush;
        wbDisWr     <= disWr;
        readAddr[0] <= ra0;
        readAddr[1] <= ra1;
    endtask

    // Bubbles in, every register read through both ports
    task automatic sweepRegisters();
        for (int r = 0; r < SweepSteps; r++) begin
            issue(Mem2WbBubble, 1'b1, 1'b0, 1'b0, 5'(r), 5'(SweepSteps - 1 - r));
        end
    endtask

    task automatic resultSelectTest();
        mem2WbS item;
        testName = "resultSelect";
        for (int i = 0; i < SelSteps; i++) begin
            item             = randItem();
            item.wbSel       = wbSelE'(2'(i));
            item.regsWr.rfWr = 1'b1;
            issue(item, 1'b1, 1'b0, 1'b0, randAddr(), randAddr());
        end
        sweepRegisters();
    endtask

    task automatic loadExtendTest();
        mem2WbS item;
        testName = "loadExtend";
        for (int kind = 0; kind < 6; kind++) begin
            for (int off = 0; off < 4; off++) begin
                for (int k = 0; k < 4; k++) begin
                    item          = randItem();
                    item.wbSel    = WbLoadData;
                    item.loadKind = loadKindE'(3'(kind));
                    item.aluOut   = {item.aluOut[31:2], 2'(off)};
                    // Every lane negative on even passes
                    if ((k % 2) == 0) begin
                        item.dmOut = item.dmOut | 32'h8080_8080;
                    end
                    item.regsWr = '{rfWr: 1'b1, hiWr: 1'b0, loWr: 1'b0};
                    issue(item, 1'b1, 1'b0, 1'b0, randAddr(), randAddr());
                end
            end
        end
        sweepRegisters();
    endtask

    task automatic stallFlushTest();
        mem2WbS item;
        mem2WbS other;
        testName = "stallFlush";
        for (int n = 0; n < StallRounds; n++) begin
            item             = randItem();
            item.regsWr.rfWr = 1'b1;
            issue(item, 1'b1, 1'b0, 1'b0, item.dst, randAddr());
            // Bus keeps changing while the stage is held
            repeat (StallHold) begin
                other        = randItem();
                other.regsWr = '{rfWr: 1'b1, hiWr: 1'b1, loWr: 1'b1};
                issue(other, 1'b0, 1'b0, 1'b0, item.dst, randAddr());
            end
            // Flush wins over a write enable
            other        = randItem();
            other.regsWr = '{rfWr: 1'b1, hiWr: 1'b1, loWr: 1'b1};
            issue(other, 1'b1, 1'b1, 1'b0, item.dst, randAddr());
            repeat (FlushIdle) begin
                issue(randItem(), 1'b0, 1'b0, 1'b0, item.dst, randAddr());
            end
        end
        sweepRegisters();
    endtask

    task automatic writeSuppressTest();
        mem2WbS      item;
        logic [31:0] r;
        testName = "writeSuppress";
        for (int n = 0; n < DisRounds; n++) begin
            item        = randItem();
            item.regsWr = '{rfWr: 1'b1, hiWr: 1'b1, loWr: 1'b1};
            issue(item, 1'b1, 1'b0, 1'b1, item.dst, randAddr());
            repeat (3) begin
                issue(randItem(), 1'b0, 1'b0, 1'b1, item.dst, randAddr());
            end
            // Item leaves without ever writing
            issue(randItem(), 1'b1, 1'b1, 1'b1, item.dst, randAddr());
        end
        // Mixed stall, flush and suppression
        for (int i = 0; i < DisRandSteps; i++) begin
            r = nextRand();
            issue(randItem(), r[1] | r[2], r[7:4] == 4'd0, r[0], randAddr(), randAddr());
        end
        sweepRegisters();
    endtask

    task automatic hiLoZeroTest();
        mem2WbS item;
        testName = "hiLoZero";
        for (int i = 0; i < HiLoSteps; i++) begin
            item             = randItem();
            item.wbSel       = WbOperandB;
            item.operandB    = item.operandB | 32'd1;
            item.regsWr.rfWr = 1'b1;
            item.regsWr.hiWr = ((i % 4) != 3);
            item.regsWr.loWr = ((i % 3) == 0);
            // Every other item aims at $zero
            if ((i % 2) == 0) begin
                item.dst = 5'd0;
            end
            issue(item, 1'b1, 1'b0, 1'b0, 5'd0, item.dst);
        end
        sweepRegisters();
    endtask

    // Reference model, updated from the inputs the DUT samples
    always @(posedge clk) begin
        if (reset) begin
            expStage = Mem2WbBubble;
            for (int i = 0; i < RegCount; i++) begin
                shadowGpr[i] = 32'd0;
            end
            shadowHi   = 32'd0;
            shadowLo   = 32'd0;
            modelReady = 1'b1;
        end else begin
            // Write from the item now in the stage
            if (!wbDisWr) begin
                wrValue = expectedResult(expStage);
                if (expStage.regsWr.rfWr && (expStage.dst != 5'd0)) begin
                    shadowGpr[expStage.dst] = wrValue;
                end
                if (expStage.regsWr.hiWr) begin
                    shadowHi = wrValue;
                end
                if (expStage.regsWr.loWr) begin
                    shadowLo = wrValue;
                end
            end
            if (wbFlush) begin
                expStage = Mem2WbBubble;
            end else if (wbWr) begin
                expStage = mem2Bus;
            end
        end
    end

    // Compare at the falling edge, all outputs settled
    always @(negedge clk) begin
        if (!reset && modelReady) begin
            expValue   = expectedResult(expStage);
            expWr      = wbDisWr ? NoWrite : expStage.regsWr;
            checkCount += 7;
            if (wbResult !== expValue) begin
                reportMismatch("wbResult", expValue, wbResult);
            end
            if (wbDst !== expStage.dst) begin
                reportMismatch("wbDst", {27'd0, expStage.dst}, {27'd0, wbDst});
            end
            if (finalWr !== expWr) begin
                reportMismatch("finalWr", {29'd0, expWr}, {29'd0, finalWr});
            end
            if (readData[0] !== shadowGpr[readAddr[0]]) begin
                reportMismatch("readData0", shadowGpr[readAddr[0]], readData[0]);
            end
            if (readData[1] !== shadowGpr[readAddr[1]]) begin
                reportMismatch("readData1", shadowGpr[readAddr[1]], readData[1]);
            end
            if (hiData !== shadowHi) begin
                reportMismatch("hiData", shadowHi, hiData);
            end
            if (loData !== shadowLo) begin
                reportMismatch("loData", shadowLo, loData);
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TimeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("checks %0d, errors %0d", checkCount, errorCount);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        wbFlush     = 1'b0;
        wbWr        = 1'b0;
        wbDisWr     = 1'b0;
        mem2Bus     = Mem2WbBubble;
        readAddr[0] = 5'd0;
        readAddr[1] = 5'd0;
        rngState    = 32'd88;
        errorCount  = 0;
        checkCount  = 0;
        cycleCount  = 0;
        modelReady  = 1'b0;
        testName    = "reset";

        repeat (ResetCycles) @(posedge clk);
        reset <= 1'b0;

        resultSelectTest();
        loadExtendTest();
        stallFlushTest();
        writeSuppressTest();
        hiLoZeroTest();

        testName = "drain";
        repeat (DrainSteps) begin
            issue(Mem2WbBubble, 1'b1, 1'b0, 1'b0, randAddr(), randAddr());
        end
        // Let the last falling-edge compare run
        @(posedge clk);

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* dv/wbTop_assertions.sv */
// Writeback bound assertions
module wbTopAssertions (
    input logic                              clk,
    input logic                              reset,
    input logic                              wbFlush,
    input logic                              wbDisWr,
    input pipeBusPkg::regsWrS                finalWr,
    input pipeBusPkg::regsWrS                wbRegsWr,
    input logic [isaPkg::RegAddrWidth-1:0]   readAddr0,
    input logic [isaPkg::RegAddrWidth-1:0]   readAddr1,
    input logic [31:0]                       readData0,
    input logic [31:0]                       readData1
);
    import pipeBusPkg::*;

    // Data cache stall blocks every write
    disWrBlocksWrite: assert property (@(posedge clk) disable iff (reset)
        wbDisWr |-> (finalWr == NoWrite))
        else $error("finalWr active while wbDisWr is high");

    // Flush leaves a bubble with no write
    flushGivesBubble: assert property (@(posedge clk) disable iff (reset)
        wbFlush |=> ((wbRegsWr == NoWrite) && (finalWr == NoWrite)))
        else $error("write type active in the cycle after a flush");

    // $zero on both read ports
    zeroRegPort0: assert property (@(posedge clk) disable iff (reset)
        (readAddr0 == '0) |-> (readData0 == 32'd0))
        else $error("register 0 read nonzero on port 0");

    zeroRegPort1: assert property (@(posedge clk) disable iff (reset)
        (readAddr1 == '0) |-> (readData1 == 32'd0))
        else $error("register 0 read nonzero on port 1");

endmodule

bind wbTop wbTopAssertions u_wbTopAssertions (
    .clk       (clk),
    .reset     (reset),
    .wbFlush   (wbFlush),
    .wbDisWr   (wbDisWr),
    .finalWr   (finalWr),
    .wbRegsWr  (wbRegsWr),
    .readAddr0 (readAddr[0]),
    .readAddr1 (readAddr[1]),
    .readData0 (readData[0]),
    .readData1 (readData[1])
);

/* source/wbTop.sv */
// Writeback subsystem top
module wbTop #(
    parameter int ReadPorts = 2
) (
    input  logic                              clk,
    input  logic                              reset,
    // Hazard unit controls
    input  logic                              wbFlush,
    input  logic                              wbWr,
    input  logic                              wbDisWr,
    // Bus from MEM2
    input  pipeBusPkg::mem2WbS                mem2Bus,
    // Register file read side
    input  logic [isaPkg::RegAddrWidth-1:0]   readAddr [ReadPorts],
    output logic [31:0]                       readData [ReadPorts],
    output logic [31:0]                       hiData,
    output logic [31:0]                       loData,
    // Exported for forwarding
    output logic [31:0]                       wbResult,
    output logic [isaPkg::RegAddrWidth-1:0]   wbDst,
    output pipeBusPkg::regsWrS                finalWr
);
    import pipeBusPkg::*;

    // Ungated write type, kept visible for checking
    regsWrS wbRegsWr;

    wbStage u_wbStage (
        .clk      (clk),
        .reset    (reset),
        .wbFlush  (wbFlush),
        .wbWr     (wbWr),
        .wbDisWr  (wbDisWr),
        .mem2Bus  (mem2Bus),
        .wbResult (wbResult),
        .wbDst    (wbDst),
        .finalWr  (finalWr),
        .wbRegsWr (wbRegsWr)
    );

    // Register file takes the gated write
    archRegFile #(
        .ReadPorts (ReadPorts)
    ) u_regFile (
        .clk      (clk),
        .reset    (reset),
        .wrEn     (finalWr),
        .wrAddr   (wbDst),
        .wrData   (wbResult),
        .readAddr (readAddr),
        .readData (readData),
        .hiData   (hiData),
        .loData   (loData)
    );

endmodule

/* source/archRegFile.sv */
// Architectural GPR file with HI and LO
module archRegFile #(
    parameter int ReadPorts = 2
) (
    input  logic                              clk,
    input  logic                              reset,
    // Write side from writeback
    input  pipeBusPkg::regsWrS                wrEn,
    input  logic [isaPkg::RegAddrWidth-1:0]   wrAddr,
    input  logic [31:0]                       wrData,
    // Read ports for decode
    input  logic [isaPkg::RegAddrWidth-1:0]   readAddr [ReadPorts],
    output logic [31:0]                       readData [ReadPorts],
    // Multiply and divide result pair
    output logic [31:0]                       hiData,
    output logic [31:0]                       loData
);
    import isaPkg::*;

    logic [31:0] gpr [RegCount];
    logic [31:0] hiReg;
    logic [31:0] loReg;

    // GPR write
    // $zero never takes a write, so it stays at its reset value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < RegCount; r++) begin
                gpr[r] <= 32'd0;
            end
        end else if (wrEn.rfWr && (wrAddr != RegZero)) begin
            gpr[wrAddr] <= wrData;
        end
    end

    // HI and LO update independently
    // MTHI and MTLO land here through the operandB select
    always_ff @(posedge clk) begin
        if (reset) begin
            hiReg <= 32'd0;
            loReg <= 32'd0;
        end else begin
            if (wrEn.hiWr) begin
                hiReg <= wrData;
            end
            if (wrEn.loWr) begin
                loReg <= wrData;
            end
        end
    end

    // Combinational reads without write-through
    // Forwarding elsewhere covers the in-flight value
    for (genvar p = 0; p < ReadPorts; p++) begin : gReadPort
        always_comb begin
            readData[p] = gpr[readAddr[p]];
        end
    end

    assign hiData = hiReg;
    assign loData = loReg;

endmodule

/* source/wbStage.sv */
// Writeback stage
module wbStage (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wbFlush,
    input  logic                              wbWr,
    // Held high while the data cache stalls the pipe
    input  logic                              wbDisWr,
    input  pipeBusPkg::mem2WbS                mem2Bus,
    // Value headed for the register file, also forwarded
    output logic [31:0]                       wbResult,
    output logic [isaPkg::RegAddrWidth-1:0]   wbDst,
    // Write type after stall gating
    output pipeBusPkg::regsWrS                finalWr,
    // Write type as registered
    output pipeBusPkg::regsWrS                wbRegsWr
);
    import isaPkg::*;
    import pipeBusPkg::*;

    mem2WbS      wbBus;
    logic [31:0] loadData;

    // Stage register
    wbPipeReg u_wbPipeReg (
        .clk     (clk),
        .reset   (reset),
        .wbFlush (wbFlush),
        .wbWr    (wbWr),
        .mem2Bus (mem2Bus),
        .wbBus   (wbBus)
    );

    // Load path, the address comes back on aluOut
    loadExtend u_loadExtend (
        .dmOut    (wbBus.dmOut),
        .addrLow  (wbBus.aluOut[1:0]),
        .loadKind (wbBus.loadKind),
        .loadData (loadData)
    );

    // Four-way result select
    always_comb begin
        case (wbBus.wbSel)
            // Link address skips the delay slot
            WbPcPlus8: begin
                wbResult = wbBus.pc + 32'd8;
            end
            WbAluOut: begin
                wbResult = wbBus.aluOut;
            end
            WbOperandB: begin
                wbResult = wbBus.operandB;
            end
            default: begin
                wbResult = loadData;
            end
        endcase
    end

    assign wbDst    = wbBus.dst;
    assign wbRegsWr = wbBus.regsWr;

    // No register write while the data cache holds the pipe
    assign finalWr = wbDisWr ? NoWrite : wbBus.regsWr;

endmodule

/* source/loadExtend.sv */
// Load data lane select and extend
module loadExtend (
    // Raw word from the data cache
    input  logic [31:0]      dmOut,
    // Low bits of the effective address
    input  logic [1:0]       addrLow,
    input  isaPkg::loadKindE loadKind,
    output logic [31:0]      loadData
);
    import isaPkg::*;

    logic [7:0]  byteLane;
    logic [15:0] halfLane;

    // Little-endian byte lanes
    // Offset 0 is the least significant byte
    always_comb begin
        case (addrLow)
            2'd0: begin
                byteLane = dmOut[7:0];
            end
            2'd1: begin
                byteLane = dmOut[15:8];
            end
            2'd2: begin
                byteLane = dmOut[23:16];
            end
            default: begin
                byteLane = dmOut[31:24];
            end
        endcase
    end

    // Halfword picked by address bit 1
    // Bit 0 is assumed clear, alignment is trapped upstream
    assign halfLane = addrLow[1] ? dmOut[31:16] : dmOut[15:0];

    // Sign or zero extension by load kind
    always_comb begin
        case (loadKind)
            LoadLb: begin
                loadData = {{24{byteLane[7]}}, byteLane};
            end
            LoadLbu: begin
                loadData = {24'd0, byteLane};
            end
            LoadLh: begin
                loadData = {{16{halfLane[15]}}, halfLane};
            end
            LoadLhu: begin
                loadData = {16'd0, halfLane};
            end
            // LW and non-loads take the word as is
            default: begin
                loadData = dmOut;
            end
        endcase
    end

endmodule

/* source/wbPipeReg.sv */
// MEM2 to WB stage register
module wbPipeReg (
    input  logic               clk,
    input  logic               reset,
    // Hazard unit controls
    input  logic               wbFlush,
    input  logic               wbWr,
    // Bus from MEM2
    input  pipeBusPkg::mem2WbS mem2Bus,
    // Registered copy for writeback
    output pipeBusPkg::mem2WbS wbBus
);
    import pipeBusPkg::*;

    // Next-state view of the stage bus
    mem2WbS nextBus;

    // Priority is flush, then write enable
    // A low wbWr holds the stalled item in place
    always_comb begin
        if (wbFlush) begin
            nextBus = Mem2WbBubble;
        end else if (wbWr) begin
            nextBus = mem2Bus;
        end else begin
            nextBus = wbBus;
        end
    end

    // Reset also leaves a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            wbBus <= Mem2WbBubble;
        end else begin
            wbBus <= nextBus;
        end
    end

endmodule

/* source/pipeBusPkg.sv */
// Pipeline bus structures, MEM2 to WB
package pipeBusPkg;

    // Register write enables
    // rfWr targets the GPR file, hiWr and loWr the multiply pair
    typedef struct packed {
        logic rfWr;
        logic hiWr;
        logic loWr;
    } regsWrS;

    // Everything the writeback stage needs from MEM2
    typedef struct packed {
        // ALU result, also the load address
        logic [31:0]                        aluOut;
        // PC of the instruction itself
        logic [31:0]                        pc;
        // Second operand, used by MTHI and MTLO
        logic [31:0]                        operandB;
        // Raw word from the data cache
        logic [31:0]                        dmOut;
        isaPkg::wbSelE                      wbSel;
        logic [isaPkg::RegAddrWidth-1:0]    dst;
        isaPkg::loadKindE                   loadKind;
        regsWrS                             regsWr;
    } mem2WbS;

    // No writes at all
    localparam regsWrS NoWrite = '{rfWr: 1'b0, hiWr: 1'b0, loWr: 1'b0};

    // Bubble loaded on reset and flush
    // Selects ALU output so the result bus reads a clean zero
    localparam mem2WbS Mem2WbBubble = '{
        aluOut:   32'd0,
        pc:       32'd0,
        operandB: 32'd0,
        dmOut:    32'd0,
        wbSel:    isaPkg::WbAluOut,
        dst:      '0,
        loadKind: isaPkg::LoadNone,
        regsWr:   NoWrite
    };

endpackage

/* source/isaPkg.sv */
// MIPS32 ISA encodings for writeback
package isaPkg;

    // General register file geometry
    localparam int RegCount     = 32;
    localparam int RegAddrWidth = 5;

    // $zero is hardwired
    localparam logic [RegAddrWidth-1:0] RegZero = 5'd0;

    // Load kind carried down from decode
    // None also covers stores and non-memory ops
    typedef enum logic [2:0] {
        LoadNone = 3'd0,
        LoadLb   = 3'd1,  // signed byte
        LoadLbu  = 3'd2,  // unsigned byte
        LoadLh   = 3'd3,  // signed halfword
        LoadLhu  = 3'd4,  // unsigned halfword
        LoadLw   = 3'd5   // full word
    } loadKindE;

    // Writeback value source
    // Encoding fixed by the result mux order
    typedef enum logic [1:0] {
        // JAL, JALR, BGEZAL link address
        WbPcPlus8  = 2'd0,
        // Arithmetic, logic and shift results
        WbAluOut   = 2'd1,
        // MTHI, MTLO move the rs value straight through
        WbOperandB = 2'd2,
        // Any load
        WbLoadData = 2'd3
    } wbSelE;

    // Width checks for the bus fields
    localparam int LoadKindWidth = $bits(loadKindE);
    localparam int WbSelWidth    = $bits(wbSelE);

endpackage
